/* design/isa_pkg.sv */
package isa_pkg;

    // data and address width
    parameter int word_size = 16;

    // instruction field positions
    parameter int opcode_lsb   = 12;
    parameter int rs_lsb       = 10;
    parameter int rt_lsb       = 8;
    parameter int rd_lsb       = 6;
    parameter int imm_width    = 8;
    parameter int func_width   = 6;
    parameter int target_width = 12;

    typedef enum logic [3:0] {
        op_bne   = 4'd0,
        op_beq   = 4'd1,
        op_bgz   = 4'd2,
        op_blz   = 4'd3,
        op_adi   = 4'd4,
        op_ori   = 4'd5,
        op_lhi   = 4'd6,
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_jmp   = 4'd9,
        op_jal   = 4'd10,
        op_rtype = 4'd15
    } opcode_e;

    // function codes of r-type instructions
    typedef enum logic [5:0] {
        fn_add = 6'd0,
        fn_sub = 6'd1,
        fn_and = 6'd2,
        fn_orr = 6'd3,
        fn_not = 6'd4,
        fn_tcp = 6'd5,
        fn_shl = 6'd6,
        fn_shr = 6'd7,
        fn_jpr = 6'd25,
        fn_jrl = 6'd26,
        fn_wwd = 6'd28,
        fn_hlt = 6'd29
    } func_e;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_tcp,
        alu_shl,
        alu_shr,
        alu_lhi,
        alu_pass_a
    } alu_op_e;

    // where an execute-stage operand comes from
    typedef enum logic [1:0] {
        from_idex  = 2'd0,
        from_exmem = 2'd1,
        from_memwb = 2'd2
    } fwd_sel_e;

endpackage

/* design/control_unit.sv */
`timescale 1ns/1ns

module control_unit (
    input  isa_pkg::opcode_e  opcode,
    input  isa_pkg::func_e    func,
    output logic              reg_dst,
    output logic              alu_src,
    output logic              is_branch,
    output logic              is_jump_i,
    output logic              is_jump_r,
    output logic              mem_read,
    output logic              mem_write,
    output logic              mem_to_reg,
    output logic              reg_write,
    output logic              is_wwd,
    output logic              is_halt,
    output pipe_pkg::alu_op_e alu_op
);

    always_comb begin
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        is_branch  = 1'b0;
        is_jump_i  = 1'b0;
        is_jump_r  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        is_wwd     = 1'b0;
        is_halt    = 1'b0;
        alu_op     = pipe_pkg::alu_add;
        case (opcode)
            isa_pkg::op_bne, isa_pkg::op_beq, isa_pkg::op_bgz, isa_pkg::op_blz: begin
                is_branch = 1'b1;
            end
            isa_pkg::op_adi, isa_pkg::op_ori, isa_pkg::op_lhi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                if (opcode == isa_pkg::op_ori) begin
                    alu_op = pipe_pkg::alu_or;
                end else if (opcode == isa_pkg::op_lhi) begin
                    alu_op = pipe_pkg::alu_lhi;
                end
            end
            isa_pkg::op_lwd: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            isa_pkg::op_swd: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            isa_pkg::op_jmp: is_jump_i = 1'b1;
            isa_pkg::op_jal: begin
                // return address goes to register 2
                is_jump_i = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::op_rtype: begin
                case (func)
                    isa_pkg::fn_wwd: begin
                        is_wwd = 1'b1;
                        alu_op = pipe_pkg::alu_pass_a;
                    end
                    isa_pkg::fn_jpr: is_jump_r = 1'b1;
                    isa_pkg::fn_jrl: begin
                        is_jump_r = 1'b1;
                        reg_write = 1'b1;
                    end
                    isa_pkg::fn_hlt: is_halt = 1'b1;
                    default: begin
                        reg_dst   = 1'b1;
                        reg_write = 1'b1;
                        case (func)
                            isa_pkg::fn_sub: alu_op = pipe_pkg::alu_sub;
                            isa_pkg::fn_and: alu_op = pipe_pkg::alu_and;
                            isa_pkg::fn_orr: alu_op = pipe_pkg::alu_or;
                            isa_pkg::fn_not: alu_op = pipe_pkg::alu_not;
                            isa_pkg::fn_tcp: alu_op = pipe_pkg::alu_tcp;
                            isa_pkg::fn_shl: alu_op = pipe_pkg::alu_shl;
                            isa_pkg::fn_shr: alu_op = pipe_pkg::alu_shr;
                            default:         alu_op = pipe_pkg::alu_add;
                        endcase
                    end
                endcase
            end
            default: alu_op = pipe_pkg::alu_add;
        endcase
    end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic                          Clk,
    input  logic                          rst_n,
    input  logic [1:0]                    rs,
    input  logic [1:0]                    rt,
    input  logic [1:0]                    rd,
    input  logic [isa_pkg::word_size-1:0] write_data,
    input  logic                          reg_write,
    output logic [isa_pkg::word_size-1:0] read_rs,
    output logic [isa_pkg::word_size-1:0] read_rt
);

    logic [isa_pkg::word_size-1:0] regs [4];

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write) begin
            regs[rd] <= write_data;
        end
    end

    // write-first so decode sees what write-back writes this cycle
    assign read_rs = (reg_write && rd == rs) ? write_data : regs[rs];
    assign read_rt = (reg_write && rd == rt) ? write_data : regs[rt];

endmodule

/* design/alu.sv */
`timescale 1ns/1ns

module alu (
    input  logic [isa_pkg::word_size-1:0] a,
    input  logic [isa_pkg::word_size-1:0] b,
    input  pipe_pkg::alu_op_e             op,
    input  isa_pkg::opcode_e              opcode,
    output logic [isa_pkg::word_size-1:0] result,
    output logic                          branch_taken
);

    localparam int ws = isa_pkg::word_size;

    always_comb begin
        case (op)
            pipe_pkg::alu_add:    result = a + b;
            pipe_pkg::alu_sub:    result = a - b;
            pipe_pkg::alu_and:    result = a & b;
            pipe_pkg::alu_or:     result = a | b;
            pipe_pkg::alu_not:    result = ~a;
            pipe_pkg::alu_tcp:    result = ~a + ws'(1);
            pipe_pkg::alu_shl:    result = {a[ws-2:0], 1'b0};
            // arithmetic shift keeps the sign
            pipe_pkg::alu_shr:    result = {a[ws-1], a[ws-1:1]};
            pipe_pkg::alu_lhi:    result = {b[7:0], 8'b0};
            default:              result = a;
        endcase
    end

    // bgz and blz look at rs alone
    always_comb begin
        case (opcode)
            isa_pkg::op_bne: branch_taken = (a != b);
            isa_pkg::op_beq: branch_taken = (a == b);
            isa_pkg::op_bgz: branch_taken = !a[ws-1] && (a != '0);
            isa_pkg::op_blz: branch_taken = a[ws-1];
            default:         branch_taken = 1'b0;
        endcase
    end

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic [1:0]         idex_rs,
    input  logic [1:0]         idex_rt,
    input  logic [1:0]         exmem_rd,
    input  logic               exmem_reg_write,
    input  logic [1:0]         memwb_rd,
    input  logic               memwb_reg_write,
    input  logic [1:0]         id_rs,
    input  logic [1:0]         id_rt,
    input  logic               id_use_rs,
    input  logic               id_use_rt,
    input  logic [1:0]         idex_rd,
    input  logic               idex_mem_read,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b,
    output logic               stall
);

    // the younger result in memory wins over write-back
    assign fwd_a = (exmem_reg_write && exmem_rd == idex_rs) ? pipe_pkg::from_exmem :
                   (memwb_reg_write && memwb_rd == idex_rs) ? pipe_pkg::from_memwb :
                                                              pipe_pkg::from_idex;

    assign fwd_b = (exmem_reg_write && exmem_rd == idex_rt) ? pipe_pkg::from_exmem :
                   (memwb_reg_write && memwb_rd == idex_rt) ? pipe_pkg::from_memwb :
                                                              pipe_pkg::from_idex;

    // load data only exists after memory, so hold decode one cycle
    assign stall = idex_mem_read &&
                   ((id_use_rs && idex_rd == id_rs) || (id_use_rt && idex_rd == id_rt));

endmodule

/* design/datapath.sv */
`timescale 1ns/1ns

module datapath (
    input  logic                          Clk,
    input  logic                          rst_n,
    output logic                          read_inst,
    output logic [isa_pkg::word_size-1:0] inst_addr,
    input  logic [isa_pkg::word_size-1:0] inst_data,
    output logic                          read_data,
    output logic                          write_data,
    output logic [isa_pkg::word_size-1:0] data_addr,
    output logic [isa_pkg::word_size-1:0] data_wr,
    input  logic [isa_pkg::word_size-1:0] data_rd,
    input  logic                          reg_dst,
    input  logic                          alu_src,
    input  logic                          is_branch,
    input  logic                          is_jump_i,
    input  logic                          is_jump_r,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic                          mem_to_reg,
    input  logic                          reg_write,
    input  logic                          is_wwd,
    input  logic                          is_halt,
    input  pipe_pkg::alu_op_e             alu_op,
    output isa_pkg::opcode_e              opcode,
    output isa_pkg::func_e                func,
    output logic                          is_halted,
    output logic [isa_pkg::word_size-1:0] num_inst,
    output logic [isa_pkg::word_size-1:0] output_port
);

    localparam int ws = isa_pkg::word_size;

    logic [ws-1:0]     pc;
    logic [ws-1:0]     next_pc;
    logic [ws-1:0]     pc_plus_one;

    logic              ifid_bubble;
    logic [ws-1:0]     ifid_inst;
    logic [ws-1:0]     ifid_pc_next;

    logic              idex_bubble;
    logic [ws-1:0]     idex_pc_next;
    logic [ws-1:0]     idex_rs_val;
    logic [ws-1:0]     idex_rt_val;
    logic [ws-1:0]     idex_imm;
    logic [1:0]        idex_rs;
    logic [1:0]        idex_rt;
    logic [1:0]        idex_rd;
    isa_pkg::opcode_e  idex_opcode;
    pipe_pkg::alu_op_e idex_alu_op;
    logic              idex_alu_src;
    logic              idex_is_branch;
    logic              idex_is_jump_r;
    logic              idex_link;
    logic              idex_mem_read;
    logic              idex_mem_write;
    logic              idex_mem_to_reg;
    logic              idex_reg_write;
    logic              idex_is_wwd;
    logic              idex_is_halt;

    logic              exmem_bubble;
    logic [ws-1:0]     exmem_result;
    logic [ws-1:0]     exmem_store;
    logic [1:0]        exmem_rd;
    logic              exmem_mem_read;
    logic              exmem_mem_write;
    logic              exmem_mem_to_reg;
    logic              exmem_reg_write;
    logic              exmem_is_wwd;
    logic              exmem_is_halt;

    logic              memwb_bubble;
    logic [ws-1:0]     memwb_result;
    logic [ws-1:0]     memwb_load;
    logic [1:0]        memwb_rd;
    logic              memwb_mem_to_reg;
    logic              memwb_reg_write;
    logic              memwb_is_wwd;
    logic              memwb_is_halt;

    logic [1:0]        id_rs;
    logic [1:0]        id_rt;
    logic [1:0]        id_rd;
    logic [7:0]        id_imm8;
    logic [ws-1:0]     id_imm;
    logic [ws-1:0]     id_rs_val;
    logic [ws-1:0]     id_rt_val;
    logic              id_use_rs;
    logic              id_use_rt;
    logic              id_jump_i;
    logic              stall;

    pipe_pkg::fwd_sel_e fwd_a;
    pipe_pkg::fwd_sel_e fwd_b;
    logic [ws-1:0]     ex_rs_val;
    logic [ws-1:0]     ex_rt_val;
    logic [ws-1:0]     alu_b;
    logic [ws-1:0]     alu_result;
    logic [ws-1:0]     ex_result;
    logic              branch_taken;
    logic              ex_jump_r;
    logic              ex_branch;
    logic              ex_redirect;

    logic              mem_reg_write;
    logic              halt_wb;
    logic              wb_write;
    logic [ws-1:0]     wb_data;

    // fetch
    assign read_inst   = !is_halted;
    assign inst_addr   = pc;
    assign pc_plus_one = pc + ws'(1);

    // decode
    assign opcode    = isa_pkg::opcode_e'(ifid_inst[isa_pkg::opcode_lsb +: 4]);
    assign func      = isa_pkg::func_e'(ifid_inst[isa_pkg::func_width-1:0]);
    assign id_rs     = ifid_inst[isa_pkg::rs_lsb +: 2];
    assign id_rt     = ifid_inst[isa_pkg::rt_lsb +: 2];
    assign id_imm8   = ifid_inst[isa_pkg::imm_width-1:0];
    // ori takes its immediate unsigned
    assign id_imm    = (opcode == isa_pkg::op_ori) ? ws'(id_imm8) : ws'($signed(id_imm8));
    assign id_rd     = (reg_write && (is_jump_i || is_jump_r)) ? 2'd2 :
                       reg_dst ? ifid_inst[isa_pkg::rd_lsb +: 2] : id_rt;
    assign id_use_rs = !ifid_bubble && !is_jump_i && opcode != isa_pkg::op_lhi;
    assign id_use_rt = !ifid_bubble &&
                       (opcode inside {isa_pkg::op_bne, isa_pkg::op_beq, isa_pkg::op_swd} ||
                        (opcode == isa_pkg::op_rtype && func inside {isa_pkg::fn_add,
                         isa_pkg::fn_sub, isa_pkg::fn_and, isa_pkg::fn_orr}));
    // a redirect from execute squashes the jump sitting in decode
    assign id_jump_i = !ifid_bubble && is_jump_i && !ex_redirect;

    // execute
    assign ex_rs_val   = (fwd_a == pipe_pkg::from_exmem) ? exmem_result :
                         (fwd_a == pipe_pkg::from_memwb) ? wb_data : idex_rs_val;
    assign ex_rt_val   = (fwd_b == pipe_pkg::from_exmem) ? exmem_result :
                         (fwd_b == pipe_pkg::from_memwb) ? wb_data : idex_rt_val;
    assign alu_b       = idex_alu_src ? idex_imm : ex_rt_val;
    assign ex_result   = idex_link ? idex_pc_next : alu_result;
    assign ex_jump_r   = !idex_bubble && idex_is_jump_r;
    assign ex_branch   = !idex_bubble && idex_is_branch && branch_taken;
    assign ex_redirect = ex_jump_r || ex_branch;

    always_comb begin
        if (stall) begin
            next_pc = pc;
        end else if (ex_jump_r) begin
            next_pc = ex_rs_val;
        end else if (id_jump_i) begin
            next_pc = {ifid_pc_next[ws-1:isa_pkg::target_width],
                       ifid_inst[isa_pkg::target_width-1:0]};
        end else if (ex_branch) begin
            next_pc = idex_pc_next + idex_imm;
        end else begin
            next_pc = pc_plus_one;
        end
    end

    // nothing younger than a retiring hlt touches memory
    assign halt_wb       = !memwb_bubble && memwb_is_halt;
    assign read_data     = !exmem_bubble && exmem_mem_read && !halt_wb;
    assign write_data    = !exmem_bubble && exmem_mem_write && !halt_wb;
    assign data_addr     = exmem_result;
    assign data_wr       = exmem_store;
    assign mem_reg_write = !exmem_bubble && exmem_reg_write;

    // write-back
    assign wb_write = !memwb_bubble && memwb_reg_write;
    assign wb_data  = memwb_mem_to_reg ? memwb_load : memwb_result;

    register_file u_regs (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .rs         (id_rs),
        .rt         (id_rt),
        .rd         (memwb_rd),
        .write_data (wb_data),
        .reg_write  (wb_write),
        .read_rs    (id_rs_val),
        .read_rt    (id_rt_val)
    );

    alu u_alu (
        .a            (ex_rs_val),
        .b            (alu_b),
        .op           (idex_alu_op),
        .opcode       (idex_opcode),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    hazard_unit u_hazard (
        .idex_rs         (idex_rs),
        .idex_rt         (idex_rt),
        .exmem_rd        (exmem_rd),
        .exmem_reg_write (mem_reg_write),
        .memwb_rd        (memwb_rd),
        .memwb_reg_write (wb_write),
        .id_rs           (id_rs),
        .id_rt           (id_rt),
        .id_use_rs       (id_use_rs),
        .id_use_rt       (id_use_rt),
        .idex_rd         (idex_rd),
        .idex_mem_read   (!idex_bubble && idex_mem_read),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .stall           (stall)
    );

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= '0;
            ifid_bubble  <= 1'b1;
            idex_bubble  <= 1'b1;
            exmem_bubble <= 1'b1;
            memwb_bubble <= 1'b1;
            is_halted    <= 1'b0;
            num_inst     <= '0;
            output_port  <= '0;
        end else if (!is_halted) begin
            if (!memwb_bubble) begin
                num_inst <= num_inst + ws'(1);
                if (memwb_is_wwd) begin
                    output_port <= memwb_result;
                end
            end
            if (halt_wb) begin
                is_halted    <= 1'b1;
                ifid_bubble  <= 1'b1;
                idex_bubble  <= 1'b1;
                exmem_bubble <= 1'b1;
                memwb_bubble <= 1'b1;
            end else begin
                pc           <= next_pc;
                ifid_bubble  <= stall ? ifid_bubble : (ex_redirect || id_jump_i);
                idex_bubble  <= stall || ex_redirect || ifid_bubble;
                exmem_bubble <= idex_bubble;
                memwb_bubble <= exmem_bubble;
            end
        end
    end

    // stage payload that the bubble bits qualify
    always_ff @(posedge Clk) begin
        if (!is_halted) begin
            if (!stall) begin
                ifid_inst    <= inst_data;
                ifid_pc_next <= pc_plus_one;
            end
            idex_pc_next     <= ifid_pc_next;
            idex_rs_val      <= id_rs_val;
            idex_rt_val      <= id_rt_val;
            idex_imm         <= id_imm;
            idex_rs          <= id_rs;
            idex_rt          <= id_rt;
            idex_rd          <= id_rd;
            idex_opcode      <= opcode;
            idex_alu_op      <= alu_op;
            idex_alu_src     <= alu_src;
            idex_is_branch   <= is_branch;
            idex_is_jump_r   <= is_jump_r;
            idex_link        <= reg_write && (is_jump_i || is_jump_r);
            idex_mem_read    <= mem_read;
            idex_mem_write   <= mem_write;
            idex_mem_to_reg  <= mem_to_reg;
            idex_reg_write   <= reg_write;
            idex_is_wwd      <= is_wwd;
            idex_is_halt     <= is_halt;
            exmem_result     <= ex_result;
            exmem_store      <= ex_rt_val;
            exmem_rd         <= idex_rd;
            exmem_mem_read   <= idex_mem_read;
            exmem_mem_write  <= idex_mem_write;
            exmem_mem_to_reg <= idex_mem_to_reg;
            exmem_reg_write  <= idex_reg_write;
            exmem_is_wwd     <= idex_is_wwd;
            exmem_is_halt    <= idex_is_halt;
            memwb_result     <= exmem_result;
            memwb_load       <= data_rd;
            memwb_rd         <= exmem_rd;
            memwb_mem_to_reg <= exmem_mem_to_reg;
            memwb_reg_write  <= exmem_reg_write;
            memwb_is_wwd     <= exmem_is_wwd;
            memwb_is_halt    <= exmem_is_halt;
        end
    end

    // every live instruction in decode carries an opcode of the ISA
    a_known_opcode: assert property (@(posedge Clk) disable iff (!rst_n)
        !ifid_bubble |-> opcode inside {isa_pkg::op_bne, isa_pkg::op_beq, isa_pkg::op_bgz,
            isa_pkg::op_blz, isa_pkg::op_adi, isa_pkg::op_ori, isa_pkg::op_lhi,
            isa_pkg::op_lwd, isa_pkg::op_swd, isa_pkg::op_jmp, isa_pkg::op_jal,
            isa_pkg::op_rtype});

    // once halted no store may start
    a_no_store_halted: assert property (@(posedge Clk) disable iff (!rst_n)
        is_halted |-> !$rose(write_data));

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top (
    input  logic                          Clk,
    input  logic                          rst_n,
    output logic                          read_inst,
    output logic [isa_pkg::word_size-1:0] inst_addr,
    input  logic [isa_pkg::word_size-1:0] inst_data,
    output logic                          read_data,
    output logic                          write_data,
    output logic [isa_pkg::word_size-1:0] data_addr,
    output logic [isa_pkg::word_size-1:0] data_wr,
    input  logic [isa_pkg::word_size-1:0] data_rd,
    output logic                          is_halted,
    output logic [isa_pkg::word_size-1:0] num_inst,
    output logic [isa_pkg::word_size-1:0] output_port
);

    isa_pkg::opcode_e  opcode;
    isa_pkg::func_e    func;
    pipe_pkg::alu_op_e alu_op;
    logic reg_dst;
    logic alu_src;
    logic is_branch;
    logic is_jump_i;
    logic is_jump_r;
    logic mem_read;
    logic mem_write;
    logic mem_to_reg;
    logic reg_write;
    logic is_wwd;
    logic is_halt;

    control_unit u_ctrl (
        .opcode     (opcode),
        .func       (func),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .is_branch  (is_branch),
        .is_jump_i  (is_jump_i),
        .is_jump_r  (is_jump_r),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .is_wwd     (is_wwd),
        .is_halt    (is_halt),
        .alu_op     (alu_op)
    );

    datapath u_dp (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .read_inst   (read_inst),
        .inst_addr   (inst_addr),
        .inst_data   (inst_data),
        .read_data   (read_data),
        .write_data  (write_data),
        .data_addr   (data_addr),
        .data_wr     (data_wr),
        .data_rd     (data_rd),
        .reg_dst     (reg_dst),
        .alu_src     (alu_src),
        .is_branch   (is_branch),
        .is_jump_i   (is_jump_i),
        .is_jump_r   (is_jump_r),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_to_reg  (mem_to_reg),
        .reg_write   (reg_write),
        .is_wwd      (is_wwd),
        .is_halt     (is_halt),
        .alu_op      (alu_op),
        .opcode      (opcode),
        .func        (func),
        .is_halted   (is_halted),
        .num_inst    (num_inst),
        .output_port (output_port)
    );

endmodule

/* dv/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;

    localparam int ws           = isa_pkg::word_size;
    localparam int prog_len     = 22;
    localparam int halt_timeout = 200;

    // program constants
    localparam logic [7:0] c_base = 8'd5;
    localparam logic [7:0] c_step = 8'd3;
    localparam logic [7:0] c_hi   = 8'h12;
    localparam logic [7:0] c_lo   = 8'h34;
    localparam logic [7:0] c_off  = 8'd2;
    localparam int jal_addr = 17;
    localparam int sub_addr = 20;
    localparam int jrl_addr = 21;

    // path 0..12, 15..17, 20, 21, 18 and the hlt at 19
    localparam logic [ws-1:0] retired_expected = 16'd20;
    localparam logic [2:0]    n_out            = 3'd6;

    logic          Clk;
    logic          rst_n;
    logic          read_inst;
    logic [ws-1:0] inst_addr;
    logic [ws-1:0] inst_data;
    logic          read_data;
    logic          write_data;
    logic [ws-1:0] data_addr;
    logic [ws-1:0] data_wr;
    logic [ws-1:0] data_rd;
    logic          is_halted;
    logic [ws-1:0] num_inst;
    logic [ws-1:0] output_port;

    logic [ws-1:0] prog [prog_len];
    logic [ws-1:0] dmem [256];
    logic [ws-1:0] expected_out [8];
    logic [ws-1:0] last_port;
    logic [2:0]    out_idx;

    cpu_top dut_i (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .read_inst   (read_inst),
        .inst_addr   (inst_addr),
        .inst_data   (inst_data),
        .read_data   (read_data),
        .write_data  (write_data),
        .data_addr   (data_addr),
        .data_wr     (data_wr),
        .data_rd     (data_rd),
        .is_halted   (is_halted),
        .num_inst    (num_inst),
        .output_port (output_port)
    );

    always #50 Clk = ~Clk;

    function automatic logic [ws-1:0] enc_r(isa_pkg::func_e fn, logic [1:0] rs,
                                             logic [1:0] rt, logic [1:0] rd);
        return {isa_pkg::op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic logic [ws-1:0] enc_i(isa_pkg::opcode_e op, logic [1:0] rs,
                                             logic [1:0] rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [ws-1:0] enc_j(isa_pkg::opcode_e op, logic [11:0] target);
        return {op, target};
    endfunction

    // fetches past the program see hlt
    assign inst_data = (inst_addr < 16'(prog_len)) ? prog[inst_addr[4:0]] :
                       enc_r(isa_pkg::fn_hlt, 2'd0, 2'd0, 2'd0);
    // the data bus carries a word only while read_data is high
    assign data_rd   = read_data ? dmem[data_addr[7:0]] : '0;

    always @(posedge Clk) begin
        if (write_data) begin
            dmem[data_addr[7:0]] <= data_wr;
        end
    end

    task automatic load_program();
        prog[0]  = enc_i(isa_pkg::op_adi, 2'd0, 2'd1, c_base);
        prog[1]  = enc_i(isa_pkg::op_adi, 2'd1, 2'd2, c_step);
        prog[2]  = enc_r(isa_pkg::fn_add, 2'd1, 2'd2, 2'd3);
        prog[3]  = enc_r(isa_pkg::fn_wwd, 2'd3, 2'd0, 2'd0);
        prog[4]  = enc_i(isa_pkg::op_lhi, 2'd0, 2'd0, c_hi);
        prog[5]  = enc_i(isa_pkg::op_ori, 2'd0, 2'd0, c_lo);
        prog[6]  = enc_r(isa_pkg::fn_wwd, 2'd0, 2'd0, 2'd0);
        prog[7]  = enc_r(isa_pkg::fn_add, 2'd0, 2'd3, 2'd3);
        // store, then load it back and use it right away
        prog[8]  = enc_i(isa_pkg::op_swd, 2'd1, 2'd3, c_off);
        prog[9]  = enc_i(isa_pkg::op_lwd, 2'd1, 2'd2, c_off);
        prog[10] = enc_r(isa_pkg::fn_add, 2'd2, 2'd1, 2'd2);
        prog[11] = enc_r(isa_pkg::fn_wwd, 2'd2, 2'd0, 2'd0);
        prog[12] = enc_i(isa_pkg::op_bne, 2'd1, 2'd2, 8'd2);
        // fall-through of the taken bne never retires
        prog[13] = enc_r(isa_pkg::fn_wwd, 2'd3, 2'd0, 2'd0);
        prog[14] = enc_r(isa_pkg::fn_wwd, 2'd0, 2'd0, 2'd0);
        prog[15] = enc_i(isa_pkg::op_beq, 2'd1, 2'd2, 8'd1);
        prog[16] = enc_r(isa_pkg::fn_wwd, 2'd1, 2'd0, 2'd0);
        prog[jal_addr] = enc_j(isa_pkg::op_jal, 12'(sub_addr));
        prog[18] = enc_r(isa_pkg::fn_wwd, 2'd2, 2'd0, 2'd0);
        prog[19] = enc_r(isa_pkg::fn_hlt, 2'd0, 2'd0, 2'd0);
        // subroutine
        prog[sub_addr] = enc_r(isa_pkg::fn_wwd, 2'd2, 2'd0, 2'd0);
        prog[jrl_addr] = enc_r(isa_pkg::fn_jrl, 2'd2, 2'd0, 2'd0);
    endtask

    task automatic fill_data_memory();
        for (int i = 0; i < 256; i++) begin
            dmem[8'(i)] = {8'(i), ~8'(i)};
        end
    endtask

    task automatic set_expected();
        expected_out[0] = 16'(c_base) + 16'(c_base) + 16'(c_step);
        expected_out[1] = {c_hi, 8'h00} | {8'h00, c_lo};
        // the stored word is r0 + r3 and the add after the load puts r1 on top
        expected_out[2] = expected_out[1] + expected_out[0] + 16'(c_base);
        expected_out[3] = 16'(c_base);
        expected_out[4] = 16'(jal_addr + 1);
        expected_out[5] = 16'(jrl_addr + 1);
        expected_out[6] = 16'hffff;
        expected_out[7] = 16'hffff;
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // every new port value is the next WWD result
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            last_port <= '0;
            out_idx   <= '0;
        end else if (output_port != last_port) begin
            last_port <= output_port;
            out_idx   <= out_idx + 3'd1;
        end
    end

    a_reset_state: assert property (@(posedge Clk)
        !rst_n |-> !read_data && !write_data && !is_halted &&
                   num_inst == '0 && output_port == '0)
        else report_failure($sformatf(
            "FAILED reset: read_data %h write_data %h is_halted %h num_inst %h output_port %h",
            read_data, write_data, is_halted, num_inst, output_port));

    a_output_count: assert property (@(posedge Clk) disable iff (!rst_n)
        output_port != last_port |-> out_idx < n_out)
        else report_failure("output_port changed more often than the program has WWD results");

    a_output_value: assert property (@(posedge Clk) disable iff (!rst_n)
        output_port != last_port |-> output_port == expected_out[out_idx])
        else report_failure($sformatf("FAILED output_port: got %h, expected %h",
            output_port, expected_out[out_idx]));

    a_halt_fetch: assert property (@(posedge Clk) disable iff (!rst_n)
        is_halted |-> !read_inst)
        else report_failure($sformatf("FAILED read_inst: got %h, expected %h while halted",
            read_inst, 1'b0));

    a_halt_count: assert property (@(posedge Clk) disable iff (!rst_n)
        is_halted |-> num_inst == retired_expected)
        else report_failure($sformatf("FAILED num_inst: got %h, expected %h",
            num_inst, retired_expected));

    a_halt_outputs: assert property (@(posedge Clk) disable iff (!rst_n)
        is_halted |-> out_idx == n_out)
        else report_failure($sformatf("FAILED WWD result count: got %h, expected %h",
            out_idx, n_out));

    a_halt_port: assert property (@(posedge Clk) disable iff (!rst_n)
        is_halted |-> output_port == expected_out[n_out - 3'd1])
        else report_failure($sformatf("FAILED output_port: got %h, expected %h after halt",
            output_port, expected_out[n_out - 3'd1]));

    initial begin
        int waited;
        Clk   = 1'b0;
        rst_n = 1'b1;
        load_program();
        fill_data_memory();
        set_expected();
        #1 rst_n = 1'b0;
        repeat (2) @(posedge Clk);
        #1 rst_n = 1'b1;
        waited = 0;
        while (!is_halted && waited < halt_timeout) begin
            @(posedge Clk);
            #1;
            waited++;
        end
        if (!is_halted) begin
            report_failure("timed out waiting for is_halted to rise");
        end else begin
            // a few more edges so the halted state gets checked
            repeat (4) @(posedge Clk);
            #1;
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* compile.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/hazard_unit.sv
design/datapath.sv
design/cpu_top.sv
dv/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module cpu_tb -f compile.f &&
./obj_dir/Vcpu_tb | tee /dev/stderr | grep -x "Simulation passed" > /dev/null &&
echo "run.sh: test passed" ||
{ echo "run.sh: test failed" >&2; exit 1; }
